// File: logic/intEdgeDetect.sv
// Request line edge detector
// Brings the raw peripheral request levels into the clock domain
// through a flop chain and emits a one-cycle pulse per rising edge
`timescale 1ns/1ps

module intEdgeDetect import nvicPkg::*; #(
	parameter int SYNC_STAGES = 2      // Legal range 2 to 4
) (
	input  logic  i_clk,
	input  logic  i_rst,
	input  RawReq i_raw,               // Asynchronous levels
	output RawReq o_pulse              // One cycle per rising edge
);

	// ------------------------------
	// Synchronizer chain
	// ------------------------------
	RawReq syncQ [SYNC_STAGES];        // Stage 0 sees the raw lines
	RawReq delayQ;                     // Last stage one cycle late
	RawReq pulseQ;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				syncQ[i] <= '0;
			end
			delayQ <= '0;
			pulseQ <= '0;
		end else begin
			syncQ[0] <= i_raw;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				syncQ[i] <= syncQ[i-1];
			end
			delayQ <= syncQ[SYNC_STAGES-1];
			// High now and low a cycle ago
			pulseQ <= syncQ[SYNC_STAGES-1] & ~delayQ;
		end
	end

	assign o_pulse = pulseQ;           // Registered, clean after reset

	// ------------------------------
	// Checks
	// ------------------------------
	// A level held high must not retrigger
	pulseSingleCycle: assert property (
		@(posedge i_clk) disable iff (i_rst)
		(o_pulse & $past(o_pulse)) == '0
	) else $error("edge detector pulse longer than one cycle");

endmodule

// File: logic/nvic.sv
// Prioritized interrupt controller core
// Holds the enable mask and the sticky flag register, merges edge
// pulses with bus writes, serves register reads and drives the
// encoded interrupt request to the CPU
`timescale 1ns/1ps

module nvic import nvicPkg::*, wbPkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,

	// Register access from the bus slave
	input  WbAddr  i_regAddr,
	input  WbData  i_regWrData,
	input  logic   i_regWr,           // One cycle per bus write
	output WbData  o_regRdData,       // Comb for the current address

	// Edge pulses from the synchronizer
	input  RawReq  i_pulse,

	// Request to the CPU
	output IntCode o_intCode,
	output logic   o_intEn
);

	// ------------------------------
	// Internal signals
	// ------------------------------
	IntVec enableQ;                    // Enable mask
	IntVec flagQ;                      // Sticky flags
	IntVec pulseVec;                   // Pulses in source order
	IntVec wrVec;                      // Write data aligned to the vector
	IntVec pending;                    // Flags passed by the mask
	logic  enableWr;
	logic  flagWr;

	// Address decode
	assign enableWr = i_regWr & (i_regAddr == ADDR_ENABLE);
	assign flagWr   = i_regWr & (i_regAddr == ADDR_FLAG);

	// Data bits 11:1 carry vector bits 10:0
	assign wrVec = i_regWrData[VEC_LSB +: NUM_SRC];

	// ------------------------------
	// Pulse expansion
	// ------------------------------
	// Raw lines skip the reserved slot
	always_comb begin
		pulseVec = '0;                     // Reserved bit stays low
		pulseVec[SRC_EXL] = i_pulse[0];
		pulseVec[SRC_I2C] = i_pulse[1];
		pulseVec[SRC_UTX] = i_pulse[2];
		pulseVec[SRC_TM3] = i_pulse[3];
		pulseVec[SRC_TM2] = i_pulse[4];
		pulseVec[SRC_TM1] = i_pulse[5];
		pulseVec[SRC_TM0] = i_pulse[6];
		pulseVec[SRC_URX] = i_pulse[7];
		pulseVec[SRC_EXH] = i_pulse[8];
		pulseVec[SRC_OVF] = i_pulse[9];
	end

	// ------------------------------
	// Registers
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			enableQ <= '0;
		end else if (enableWr) begin
			enableQ <= wrVec;
		end
	end

	// Write replaces everything and drops a same-cycle pulse
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			flagQ <= '0;
		end else if (flagWr) begin
			flagQ <= wrVec;                // Only way to clear flags
		end else begin
			flagQ <= flagQ | pulseVec;     // Sticky set
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb begin
		case (i_regAddr)
			ADDR_ENABLE: o_regRdData = WbData'(enableQ) << VEC_LSB;
			ADDR_FLAG:   o_regRdData = WbData'(flagQ) << VEC_LSB;
			default:     o_regRdData = '0;  // Unused words
		endcase
	end

	// ------------------------------
	// Priority encoder
	// ------------------------------
	assign pending = enableQ & flagQ;

	nvicEncoder i_nvicEncoder (
		.i_pending (pending),
		.o_code    (o_intCode),
		.o_valid   (o_intEn)              // Code 0 means no request
	);

	// ------------------------------
	// Checks
	// ------------------------------
	// Pulses never reach the reserved source
	rsvdOnlyByWrite: assert property (
		@(posedge i_clk) disable iff (i_rst)
		$rose(flagQ[SRC_RSVD]) |-> $past(flagWr)
	) else $error("reserved flag set without a bus write");

endmodule

// File: logic/nvicEncoder.sv
// Interrupt priority encoder
// Reports the highest set pending bit as index+1, or zero when
// nothing is pending. Purely combinational
`timescale 1ns/1ps

module nvicEncoder import nvicPkg::*; (
	input  IntVec  i_pending,          // Enabled and flagged sources
	output IntCode o_code,             // 0 = none
	output logic   o_valid             // Any source pending
);

	// ------------------------------
	// Encoder
	// ------------------------------
	// Ascending scan so the highest set bit is the last one written
	always_comb begin
		o_code = '0;
		for (int i = 0; i < NUM_SRC; i++) begin
			if (i_pending[i]) begin
				o_code = IntCode'(i + 1);
			end
		end
	end

	assign o_valid = |i_pending;       // Straight from the inputs

	// ------------------------------
	// Checks
	// ------------------------------
	// No clock in this block so these are immediate checks
	always_comb begin
		// Scan result and OR reduction must agree
		assert (o_valid == (o_code != '0))
		else $error("encoder valid %0b disagrees with code %0d", o_valid, o_code);
		// Code range is 0 to NUM_SRC
		assert (o_code <= IntCode'(NUM_SRC))
		else $error("encoder code %0d out of range", o_code);
	end

endmodule

// File: logic/nvicPkg.sv
// Interrupt controller package
// Types for the source vector, the raw request lines and the encoded
// interrupt number, plus the bit position of every source
package nvicPkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int NUM_SRC = 11;        // Source vector incl. reserved bit
	localparam int NUM_RAW = 10;        // Physical request lines

	typedef logic [3:0]         IntCode; // 0 = none, 1..11 = source index+1
	typedef logic [NUM_SRC-1:0] IntVec;  // One bit per source
	typedef logic [NUM_RAW-1:0] RawReq;  // Source order, reserved bit removed

	// ------------------------------
	// Source positions in IntVec
	// ------------------------------
	// Higher index wins in the encoder
	localparam int SRC_EXL  = 0;        // Low ext pin, lowest priority
	localparam int SRC_RSVD = 1;        // Never set by hardware
	localparam int SRC_I2C  = 2;
	localparam int SRC_UTX  = 3;        // UART TX byte
	localparam int SRC_TM3  = 4;        // Timer 3 overflow
	localparam int SRC_TM2  = 5;
	localparam int SRC_TM1  = 6;
	localparam int SRC_TM0  = 7;
	localparam int SRC_URX  = 8;        // UART RX byte
	localparam int SRC_EXH  = 9;        // High ext pin
	localparam int SRC_OVF  = 10;       // Overflow, highest priority

endpackage

// File: logic/nvicTop.sv
// Interrupt controller top level
// Bus slave, request line edge detector and controller core
// wired together. Ten raw peripheral lines in, encoded request out
`timescale 1ns/1ps

module nvicTop import nvicPkg::*, wbPkg::*; #(
	parameter int SYNC_STAGES = 2      // Synchronizer depth, 2 to 4
) (
	input  logic   i_clk,
	input  logic   i_rst,

	// Wishbone classic slave
	input  logic   i_wbCyc,
	input  logic   i_wbStb,
	input  logic   i_wbWe,
	input  WbAddr  i_wbAdr,
	input  WbData  i_wbDat,
	output WbData  o_wbDat,
	output logic   o_wbAck,

	// Raw peripheral request levels
	input  logic   i_intOVF,
	input  logic   i_intEXH,
	input  logic   i_intURX,
	input  logic   i_intTM0,
	input  logic   i_intTM1,
	input  logic   i_intTM2,
	input  logic   i_intTM3,
	input  logic   i_intUTX,
	input  logic   i_intI2C,
	input  logic   i_intEXL,

	// Request to the CPU
	output IntCode o_intCode,
	output logic   o_intEn
);

	// ------------------------------
	// Wires
	// ------------------------------
	RawReq rawReq;
	RawReq pulse;
	WbAddr regAddr;
	WbData regWrData;
	WbData regRdData;
	logic  regWr;

	// Lowest priority first, reserved slot left out
	assign rawReq = {i_intOVF, i_intEXH, i_intURX, i_intTM0, i_intTM1,
	                 i_intTM2, i_intTM3, i_intUTX, i_intI2C, i_intEXL};

	// ------------------------------
	// Instances
	// ------------------------------
	wbNvicSlave i_wbNvicSlave (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wbCyc     (i_wbCyc),
		.i_wbStb     (i_wbStb),
		.i_wbWe      (i_wbWe),
		.i_wbAdr     (i_wbAdr),
		.i_wbDat     (i_wbDat),
		.o_wbDat     (o_wbDat),
		.o_wbAck     (o_wbAck),
		.o_regAddr   (regAddr),
		.o_regWrData (regWrData),
		.o_regWr     (regWr),
		.i_regRdData (regRdData)
	);

	intEdgeDetect #(
		.SYNC_STAGES (SYNC_STAGES)
	) i_intEdgeDetect (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_raw   (rawReq),
		.o_pulse (pulse)
	);

	nvic i_nvic (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_regAddr   (regAddr),
		.i_regWrData (regWrData),
		.i_regWr     (regWr),
		.o_regRdData (regRdData),
		.i_pulse     (pulse),
		.o_intCode   (o_intCode),
		.o_intEn     (o_intEn)
	);

endmodule

// File: logic/wbNvicSlave.sv
// Wishbone classic slave for the interrupt controller
// Samples a request, answers with a one-cycle ack and turns the
// cycle into a register write strobe or a captured read
`timescale 1ns/1ps

module wbNvicSlave import wbPkg::*; (
	input  logic  i_clk,
	input  logic  i_rst,

	// Wishbone slave side
	input  logic  i_wbCyc,
	input  logic  i_wbStb,
	input  logic  i_wbWe,
	input  WbAddr i_wbAdr,
	input  WbData i_wbDat,
	output WbData o_wbDat,
	output logic  o_wbAck,

	// Register side
	output WbAddr o_regAddr,
	output WbData o_regWrData,
	output logic  o_regWr,
	input  WbData i_regRdData
);

	typedef enum logic {IDLE, ACK} SlaveState;

	SlaveState state;
	WbAddr     addrQ;                  // Latched request
	WbData     dataQ;
	logic      weQ;
	WbData     rdDataQ;
	logic      request;

	assign request = i_wbCyc & i_wbStb;

	// ------------------------------
	// FSM
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= IDLE;
			weQ   <= 1'b0;
		end else begin
			case (state)
				IDLE: if (request) begin
					state <= ACK;
					weQ   <= i_wbWe;
				end
				ACK:     state <= IDLE;     // Ack lasts one cycle
				default: state <= IDLE;
			endcase
		end
	end

	// Payload latches with the request
	always_ff @(posedge i_clk) begin
		if (state == IDLE && request) begin
			addrQ   <= i_wbAdr;
			dataQ   <= i_wbDat;
			rdDataQ <= i_regRdData;        // Read value for the ack cycle
		end
	end

	// Live address while idle so the read mux sees it before the edge
	assign o_regAddr   = (state == ACK) ? addrQ : i_wbAdr;
	assign o_regWrData = dataQ;
	assign o_regWr     = (state == ACK) & weQ;
	assign o_wbAck     = (state == ACK);
	assign o_wbDat     = rdDataQ;

	// ------------------------------
	// Checks
	// ------------------------------
	ackAfterRequest: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_wbAck |-> $past(i_wbCyc & i_wbStb)
	) else $error("ack without a preceding request");

	ackOneCycle: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_wbAck |=> !o_wbAck
	) else $error("ack held for two cycles");

endmodule

// File: logic/wbPkg.sv
// Wishbone side package
// Bus word and address types and the register map of the
// interrupt controller
package wbPkg;

	// ------------------------------
	// Bus types
	// ------------------------------
	typedef logic [1:0]  WbAddr;        // Register word address
	typedef logic [15:0] WbData;        // Bus data word

	// ------------------------------
	// Register map
	// ------------------------------
	localparam WbAddr ADDR_ENABLE = 2'd0;  // Enable mask
	localparam WbAddr ADDR_FLAG   = 2'd1;  // Sticky flags
	// Addresses 2 and 3 read as zero

	// Vector bit 0 sits at this data bit
	localparam int VEC_LSB = 1;

endpackage

// File: run.sh
#!/bin/sh
# Builds the interrupt controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module nvicTopTb \
	-Mdir obj_dir -o simNvic

output=$(./obj_dir/simNvic)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// File: src.f
logic/nvicPkg.sv
logic/wbPkg.sv
logic/intEdgeDetect.sv
logic/nvicEncoder.sv
logic/nvic.sv
logic/wbNvicSlave.sv
logic/nvicTop.sv
verification/nvicTopTb.sv

// File: verification/nvicTopTb.sv
// Interrupt controller testbench
// Runs a table of bus accesses, request line edges and code checks
// against shadow copies of the enable and flag registers
`timescale 1ns/1ps

module nvicTopTb import nvicPkg::*, wbPkg::*; ();

	localparam int TIMEOUT   = 20;     // Cycles or polls per wait
	localparam int ALL_LINES = 15;     // Line index for every source

	typedef enum {OP_WR, OP_RD, OP_RAISE, OP_DROP, OP_CODE, OP_RAND} TbOp;

	logic        clk;
	logic        rst;
	logic        wbCyc, wbStb, wbWe, wbAck;
	WbAddr       wbAdr;
	WbData       wbDat, wbRdDat;
	IntVec       lines;                // Raw levels in source order
	IntCode      intCode;
	logic        intEn;
	IntVec       enModel, flagModel;   // Shadow registers
	logic [31:0] lcgState;
	int          errors, timeouts, checks;

	// Stimulus table, one entry per row
	TbOp   opQ[$];
	int    idxQ[$];                    // Address or source index
	WbData dataQ[$];
	int    expQ[$];                    // Read value or code or -1 when unused
	string nameQ[$];

	always #20 clk = ~clk;             // 40 ns period

	nvicTop #(.SYNC_STAGES(2)) i_nvicTop (
		.i_clk(clk), .i_rst(rst),
		.i_wbCyc(wbCyc), .i_wbStb(wbStb), .i_wbWe(wbWe), .i_wbAdr(wbAdr),
		.i_wbDat(wbDat), .o_wbDat(wbRdDat), .o_wbAck(wbAck),
		.i_intOVF(lines[SRC_OVF]), .i_intEXH(lines[SRC_EXH]), .i_intURX(lines[SRC_URX]),
		.i_intTM0(lines[SRC_TM0]), .i_intTM1(lines[SRC_TM1]), .i_intTM2(lines[SRC_TM2]),
		.i_intTM3(lines[SRC_TM3]), .i_intUTX(lines[SRC_UTX]), .i_intI2C(lines[SRC_I2C]),
		.i_intEXL(lines[SRC_EXL]),
		.o_intCode(intCode), .o_intEn(intEn)
	);

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Vector bits 10:0 sit in word bits 11:1
	function automatic WbData flagWord();
		return {4'b0000, flagModel, 1'b0};
	endfunction

	function automatic IntCode expectedCode();
		IntVec pending;
		pending = enModel & flagModel;
		for (int i = NUM_SRC - 1; i >= 0; i--) begin
			if (pending[i]) return IntCode'(i + 1);  // Highest index wins
		end
		return '0;                         // Nothing pending
	endfunction

	// ------------------------------
	// Bus access
	// ------------------------------
	// Request held until ack and released on the next edge
	task automatic busCycle(input logic we, input WbAddr addr, input WbData data,
			output WbData rdData);
		int cycles;
		cycles = 0;
		@(posedge clk);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe  <= we;
		wbAdr <= addr;
		wbDat <= data;
		do begin
			@(negedge clk);
			cycles++;
		end while (!wbAck && cycles < TIMEOUT);
		rdData = wbRdDat;                  // Valid with ack
		if (!wbAck) begin
			$display("Bus access to address %0d got no ack in %0d cycles",
				addr, cycles);
			timeouts++;
		end
		@(posedge clk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
	endtask

	task automatic wbWrite(input WbAddr addr, input WbData data);
		WbData ignored;
		busCycle(1'b1, addr, data, ignored);
		if (addr == ADDR_ENABLE) enModel = data[11:1];
		if (addr == ADDR_FLAG) flagModel = data[11:1];  // Replaces every flag
	endtask

	task automatic wbRead(input WbAddr addr, output WbData data);
		busCycle(1'b0, addr, 16'h0000, data);
	endtask

	// Only a low to high change sets a shadow flag, and then the DUT is polled
	task automatic driveLine(input int src, input logic level, input string name);
		WbData rd;
		int polls;
		polls = 0;
		@(posedge clk);
		for (int i = 0; i < NUM_SRC; i++) begin
			if ((src == ALL_LINES || src == i) && i != SRC_RSVD) begin
				if (level && !lines[i]) flagModel[i] = 1'b1;
				lines[i] <= level;
			end
		end
		do begin
			wbRead(ADDR_FLAG, rd);
			polls++;
		end while (rd !== flagWord() && polls < TIMEOUT);
		checks++;
		if (rd !== flagWord()) begin
			$display("FAIL %s: expected flags %h, actual %h", name, flagWord(), rd);
			errors++;
		end
	endtask

	// Code polled at the falling edge until it matches the model
	task automatic checkCode(input int tableCode, input string name);
		IntCode want;
		int cycles;
		want = expectedCode();
		cycles = 0;
		if (tableCode >= 0 && tableCode != int'(want)) begin
			$display("Row %s lists code %0d but the model gives %0d",
				name, tableCode, want);
			errors++;
		end
		do begin
			@(negedge clk);
			cycles++;
		end while (intCode !== want && cycles < TIMEOUT);
		checks++;
		if (intCode !== want || intEn !== (want != 0)) begin
			$display("FAIL %s: expected code %0d en %0b, actual code %0d en %0b",
				name, want, want != 0, intCode, intEn);
			errors++;
		end
	endtask

	task automatic applyRow(input int r);
		WbData rd;
		logic [31:0] rnd;
		case (opQ[r])
			OP_WR:    wbWrite(WbAddr'(idxQ[r]), dataQ[r]);
			OP_RAISE: driveLine(idxQ[r], 1'b1, nameQ[r]);
			OP_DROP:  driveLine(idxQ[r], 1'b0, nameQ[r]);
			OP_CODE:  checkCode(expQ[r], nameQ[r]);
			OP_RD: begin
				wbRead(WbAddr'(idxQ[r]), rd);
				checks++;
				if (rd !== WbData'(expQ[r])) begin
					$display("FAIL %s: expected %h, actual %h",
						nameQ[r], WbData'(expQ[r]), rd);
					errors++;
				end
			end
			OP_RAND: begin
				rnd = lcgNext();
				wbWrite(ADDR_ENABLE, rnd[23:8]);   // Upper LCG bits as the mask
				checkCode(-1, nameQ[r]);
			end
		endcase
	endtask

	// ------------------------------
	// Stimulus table
	// ------------------------------
	function automatic void addRow(TbOp op, int idx, WbData data, int want, string name);
		opQ.push_back(op);
		idxQ.push_back(idx);
		dataQ.push_back(data);
		expQ.push_back(want);
		nameQ.push_back(name);
	endfunction

	// Op, address or line, write data, expected, name
	function automatic void buildTable();
		addRow(OP_CODE,  0,         'h0000, 0,      "reset code");
		addRow(OP_RD,    0,         'h0000, 'h0000, "reset enable");
		addRow(OP_RD,    1,         'h0000, 'h0000, "reset flag");
		addRow(OP_WR,    0,         'hFFFF, -1,     "enable all ones");
		addRow(OP_RD,    0,         'h0000, 'h0FFE, "enable readback");
		// Unused words must not alias onto either register
		addRow(OP_WR,    2,         'h0000, -1,     "write addr 2");
		addRow(OP_WR,    3,         'hFFFF, -1,     "write addr 3");
		addRow(OP_RD,    2,         'h0000, 'h0000, "read addr 2");
		addRow(OP_RD,    3,         'h0000, 'h0000, "read addr 3");
		addRow(OP_RD,    0,         'h0000, 'h0FFE, "enable kept");
		addRow(OP_RD,    1,         'h0000, 'h0000, "flag kept");
		// Flag capture under a zero mask
		addRow(OP_WR,    0,         'h0000, -1,     "mask off");
		addRow(OP_RAISE, SRC_TM1,   'h0000, -1,     "raise TM1");
		addRow(OP_RD,    1,         'h0000, 'h0080, "TM1 flag");
		addRow(OP_CODE,  0,         'h0000, 0,      "TM1 masked");
		addRow(OP_WR,    0,         'h0080, -1,     "enable TM1");
		addRow(OP_CODE,  0,         'h0000, 7,      "TM1 code");
		// Priority
		addRow(OP_WR,    0,         'h0FFE, -1,     "enable all");
		addRow(OP_WR,    1,         'h0000, -1,     "clear flags");
		addRow(OP_RAISE, SRC_EXL,   'h0000, -1,     "raise EXL");
		addRow(OP_RAISE, SRC_TM3,   'h0000, -1,     "raise TM3");
		addRow(OP_RAISE, SRC_OVF,   'h0000, -1,     "raise OVF");
		addRow(OP_CODE,  0,         'h0000, 11,     "OVF wins");
		addRow(OP_WR,    1,         'h0022, -1,     "clear OVF");
		addRow(OP_CODE,  0,         'h0000, 5,      "TM3 wins");
		addRow(OP_WR,    1,         'h0002, -1,     "clear TM3");
		addRow(OP_CODE,  0,         'h0000, 1,      "EXL left");
		// Held level does not retrigger
		addRow(OP_RD,    1,         'h0000, 'h0002, "TM1 held high");
		addRow(OP_DROP,  SRC_TM1,   'h0000, -1,     "drop TM1");
		addRow(OP_RAISE, SRC_TM1,   'h0000, -1,     "new TM1 edge");
		addRow(OP_CODE,  0,         'h0000, 7,      "TM1 again");
		// Random masks over every source
		addRow(OP_DROP,  ALL_LINES, 'h0000, -1,     "drop all");
		addRow(OP_WR,    1,         'h0000, -1,     "clear flags");
		addRow(OP_RAISE, ALL_LINES, 'h0000, -1,     "raise all");
		for (int i = 0; i < 8; i++) begin
			addRow(OP_RAND, 0, 'h0000, -1, $sformatf("random mask %0d", i));
		end
		// Reserved source
		addRow(OP_WR,    0,         'h0004, -1,     "enable reserved");
		addRow(OP_CODE,  0,         'h0000, 0,      "reserved clear");
		addRow(OP_WR,    1,         'h0004, -1,     "write reserved");
		addRow(OP_RD,    1,         'h0000, 'h0004, "reserved readback");
		addRow(OP_CODE,  0,         'h0000, 2,      "reserved code");
		addRow(OP_DROP,  ALL_LINES, 'h0000, -1,     "drop all");
		addRow(OP_WR,    1,         'h0000, -1,     "clear flags");
		addRow(OP_RAISE, ALL_LINES, 'h0000, -1,     "raise all");
		addRow(OP_RD,    1,         'h0000, 'h0FFA, "hardware skips reserved");
		addRow(OP_CODE,  0,         'h0000, 0,      "no reserved code");
	endfunction

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		clk = 1'b0;
		rst   <= 1'b1;
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
		wbAdr <= '0;
		wbDat <= '0;
		lines <= '0;
		enModel   = '0;
		flagModel = '0;
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		lcgState  = 32'h49c0ae39;
		buildTable();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < opQ.size(); r++) begin
			applyRow(r);
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
